// ==== walkie_pkg.sv ====
`default_nettype none

package walkie_pkg;

  // Wishbone bus widths
  localparam int ADDR_W = 32;                 // Byte address on the bus
  localparam int DATA_W = 32;                 // One SRAM word
  localparam int SEL_W  = DATA_W / 8;         // Byte lanes per word

  // 8-bit unsigned audio sample as produced by the ADC
  typedef logic [7:0] sample_t;

  // Effect select as it arrives from the top level
  typedef enum logic [1:0] {
    EFF_BYPASS     = 2'd0,                    // Sample passes unchanged
    EFF_ECHO       = 2'd1,                    // Mix with delay line
    EFF_HALF_LEVEL = 2'd2,                    // Halved sample
    EFF_MUTE       = 2'd3                     // Silence
  } effect_e;

  // One SRAM word, either the bus view or four packed samples
  typedef union packed {
    logic [DATA_W-1:0]   raw;                 // As seen on wdati and wdato
    sample_t [SEL_W-1:0] lane;                // Lane n holds sample index with low bits n
  } mem_word_u;

endpackage

`default_nettype wire

// ==== mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
  import walkie_pkg::*;

  logic                 req_valid;            // One-cycle request, costs one credit
  logic                 req_we;               // High for write
  logic [ADDR_W-1:0]    req_addr;             // Word address
  logic [SEL_W-1:0]     req_sel;              // Active byte lane
  mem_word_u            req_data;             // Write data
  logic                 rsp_valid;            // Read data valid
  mem_word_u            rsp_data;             // Read data
  logic                 credit_return;        // One pulse per finished request

  modport requester (
    output req_valid, req_we, req_addr, req_sel, req_data,
    input  rsp_valid, rsp_data, credit_return
  );

  modport responder (
    input  req_valid, req_we, req_addr, req_sel, req_data,
    output rsp_valid, rsp_data, credit_return
  );

endinterface

`default_nettype wire

// ==== clk_edge_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_edge_divider #(
  parameter int COUNT = 15,                   // Half period minus one in hwclk cycles
  parameter int WIDTH = 4                     // Counter width, must hold COUNT
) (
  input  logic hwclk,
  input  logic rst_n,
  output logic clk_out,                       // Divided clock, used as a level
  output logic past_clk_out                   // clk_out one hwclk later for edge detect
);

  logic [WIDTH-1:0] count;                    // Half period counter

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      count        <= '0;
      clk_out      <= 1'b0;
      past_clk_out <= 1'b0;
    end else begin
      past_clk_out <= clk_out;                // Delayed copy
      if (count == WIDTH'(COUNT)) begin
        count   <= '0;                        // Reload
        clk_out <= ~clk_out;                  // Toggle every COUNT+1 cycles
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== i2s_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_receiver (
  input  logic                hwclk,
  input  logic                rst_n,
  input  logic                adc_serial_in,  // Serial data from ADC
  input  logic                bit_clk,        // Bit clock from divider
  input  logic                past_bit_clk,   // Previous bit clock level
  output logic                ws,             // Word select to ADC
  output walkie_pkg::sample_t sample,         // Assembled sample
  output logic                sample_valid    // One-cycle strobe
);
  import walkie_pkg::*;

  logic       rise;                           // Rising bit edge this cycle
  logic [3:0] bit_cnt;                        // Position in 16 period frame
  sample_t    shreg;                          // Incoming bits, MSB first

  assign rise = bit_clk && !past_bit_clk;
  assign ws   = bit_cnt[3];                   // Low for periods 0 to 7

  // Frame position and valid strobe
  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      bit_cnt      <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;                   // Default no strobe
      if (rise) begin
        bit_cnt <= bit_cnt + 1'b1;            // Wraps after 16 periods
        if (bit_cnt == 4'd7) begin
          sample_valid <= 1'b1;               // Eighth bit just captured
        end
      end
    end
  end

  // Data capture while ws is low
  always_ff @(posedge hwclk) begin
    if (rise && !bit_cnt[3]) begin
      shreg <= {shreg[6:0], adc_serial_in};   // Shift in next bit
    end
    if (rise && bit_cnt == 4'd7) begin
      sample <= {shreg[6:0], adc_serial_in};  // Complete word incl. LSB
    end
  end

endmodule

`default_nettype wire

// ==== echo_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_engine #(
  parameter int DELAY_SAMPLES = 64,           // Echo distance, power of two
  parameter int CREDITS       = 2             // Requests allowed in flight
) (
  input  logic                hwclk,
  input  logic                rst_n,
  input  walkie_pkg::effect_e effect,         // Selected effect
  input  walkie_pkg::sample_t sample,         // From receiver
  input  logic                sample_valid,
  mem_req_if.requester        mem,            // Delay line storage
  output walkie_pkg::sample_t out_sample,     // To transmitter
  output logic                out_valid
);
  import walkie_pkg::*;

  localparam int BUF_SAMPLES = DELAY_SAMPLES * 2;      // Delay line length
  localparam int PTR_W       = $clog2(BUF_SAMPLES);    // Sample index width
  localparam int CRED_W      = $clog2(CREDITS + 1);    // Credit counter width

  localparam logic [1:0] ST_IDLE  = 2'd0;     // Waiting for a sample
  localparam logic [1:0] ST_WRITE = 2'd1;     // Store new sample
  localparam logic [1:0] ST_READ  = 2'd2;     // Fetch delayed sample
  localparam logic [1:0] ST_WAIT  = 2'd3;     // Read data pending

  logic [1:0]        state;
  logic [PTR_W-1:0]  wr_ptr;                  // Index of the sample being written
  logic [PTR_W-1:0]  rd_idx;                  // Index DELAY_SAMPLES back
  logic [CRED_W-1:0] credits;                 // Free request slots
  logic [1:0]        lane_idx;                // Byte lane of current request
  logic              issue;                   // Request leaves this cycle
  sample_t           cur_sample;              // Sample in progress
  mem_word_u         wr_word;                 // Write word with one lane filled

  // Wraps modulo buffer length
  assign rd_idx = wr_ptr - PTR_W'(DELAY_SAMPLES);

  // Requests only go out while a credit is held
  assign issue    = ((state == ST_WRITE) || (state == ST_READ)) && (credits != '0);
  assign lane_idx = wr_ptr[1:0];              // Read lane equals write lane as delay is a multiple of four

  assign mem.req_valid = issue;
  assign mem.req_we    = (state == ST_WRITE);
  assign mem.req_addr  = (state == ST_WRITE) ? ADDR_W'(wr_ptr >> 2) : ADDR_W'(rd_idx >> 2);
  assign mem.req_sel   = SEL_W'(1) << lane_idx;  // One hot lane
  assign mem.req_data  = wr_word;

  always_comb begin
    wr_word.raw               = '0;           // Unused lanes are masked by sel
    wr_word.lane[wr_ptr[1:0]] = cur_sample;   // Sample in its own lane
  end

  // Control FSM and credit accounting
  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      wr_ptr    <= '0;
      credits   <= CRED_W'(CREDITS);          // Full credit after reset
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      credits   <= credits + CRED_W'(mem.credit_return) - CRED_W'(issue);
      case (state)
        ST_IDLE: begin
          if (sample_valid) begin
            if (effect == EFF_ECHO) begin
              state <= ST_WRITE;              // Needs delay line
            end else begin
              out_valid <= 1'b1;              // Result ready next cycle
            end
          end
        end
        ST_WRITE: begin
          if (issue) begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (issue) begin
            state <= ST_WAIT;
          end
        end
        default: begin
          if (mem.rsp_valid) begin            // Only reads respond
            out_valid <= 1'b1;
            wr_ptr    <= wr_ptr + 1'b1;       // Advance circular buffer
            state     <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Sample path, new samples dropped unless idle
  always_ff @(posedge hwclk) begin
    if (state == ST_IDLE && sample_valid) begin
      cur_sample <= sample;
      case (effect)
        EFF_BYPASS:     out_sample <= sample;
        EFF_HALF_LEVEL: out_sample <= sample >> 1;
        EFF_MUTE:       out_sample <= '0;
        default:        out_sample <= out_sample;  // Echo result comes later
      endcase
    end
    if (state == ST_WAIT && mem.rsp_valid) begin
      // Both halves rounded down, sum cannot overflow
      out_sample <= (cur_sample >> 1) + (mem.rsp_data.lane[rd_idx[1:0]] >> 1);
    end
  end

endmodule

`default_nettype wire

// ==== wishbone_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module wishbone_manager #(
  parameter int CREDITS = 2                   // FIFO depth, matches requester credits
) (
  input  logic                              hwclk,
  input  logic                              rst_n,
  mem_req_if.responder                      mem,
  input  logic [walkie_pkg::DATA_W-1:0]     wdati,   // Read data from SRAM
  input  logic                              wack,
  output logic [walkie_pkg::ADDR_W-1:0]     wadr,    // Byte address
  output logic [walkie_pkg::DATA_W-1:0]     wdato,
  output logic [walkie_pkg::SEL_W-1:0]      wsel,
  output logic                              wwe,
  output logic                              wstb,
  output logic                              wcyc
);
  import walkie_pkg::*;

  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CNT_W = $clog2(CREDITS + 1);

  // Request FIFO storage
  logic             fifo_we   [CREDITS];
  logic [ADDR_W-1:0] fifo_addr [CREDITS];
  logic [SEL_W-1:0] fifo_sel  [CREDITS];
  mem_word_u        fifo_data [CREDITS];

  logic [PTR_W-1:0] wr_ptr;                   // Next free slot
  logic [PTR_W-1:0] rd_ptr;                   // Oldest request
  logic [CNT_W-1:0] fifo_count;               // Requests not yet finished on bus
  logic             pop;                      // Start a bus cycle
  logic             done;                     // Bus cycle ends this cycle

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop  = !wcyc && (fifo_count != '0);  // Bus idle and work queued
  assign done = wstb && wack;

  // Pointers, bus control and response strobes
  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      wr_ptr            <= '0;
      rd_ptr            <= '0;
      fifo_count        <= '0;
      wcyc              <= 1'b0;
      wstb              <= 1'b0;
      wwe               <= 1'b0;
      mem.credit_return <= 1'b0;
      mem.rsp_valid     <= 1'b0;
    end else begin
      mem.credit_return <= done;              // Slot freed
      mem.rsp_valid     <= done && !wwe;      // Reads only
      fifo_count        <= fifo_count + CNT_W'(mem.req_valid) - CNT_W'(done);
      if (mem.req_valid) begin
        wr_ptr <= next_ptr(wr_ptr);           // Always accepted
      end
      if (pop) begin
        wcyc   <= 1'b1;                       // Classic cycle starts
        wstb   <= 1'b1;
        wwe    <= fifo_we[rd_ptr];
        rd_ptr <= next_ptr(rd_ptr);
      end else if (done) begin
        wcyc <= 1'b0;
        wstb <= 1'b0;
        wwe  <= 1'b0;
      end
    end
  end

  // Payload path
  always_ff @(posedge hwclk) begin
    if (mem.req_valid) begin
      fifo_we[wr_ptr]   <= mem.req_we;
      fifo_addr[wr_ptr] <= mem.req_addr;
      fifo_sel[wr_ptr]  <= mem.req_sel;
      fifo_data[wr_ptr] <= mem.req_data;
    end
    if (pop) begin
      wadr  <= {fifo_addr[rd_ptr][ADDR_W-3:0], 2'b00};  // Word to byte address
      wdato <= fifo_data[rd_ptr].raw;
      wsel  <= fifo_sel[rd_ptr];
    end
    if (done) begin
      mem.rsp_data.raw <= wdati;              // Captured with the ack
    end
  end

endmodule

`default_nettype wire

// ==== i2s_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_transmitter #(
  parameter int COUNT = 15,                   // Bit clock half period minus one
  parameter int WIDTH = 4                     // Divider counter width
) (
  input  logic                hwclk,
  input  logic                rst_n,
  input  walkie_pkg::sample_t out_sample,     // Processed sample
  input  logic                out_valid,
  input  logic [2:0]          vol,            // Right shift amount
  output logic                bit_clk_out,    // Bit clock to DAC
  output logic                dac_out,        // Serial data to DAC
  output logic                word_select
);
  import walkie_pkg::*;

  logic       past_bit_clk;
  logic       fall;                           // Falling bit edge this cycle
  logic [3:0] bit_cnt;                        // Position in 16 period frame
  sample_t    hold;                           // Last scaled sample, repeated if idle
  sample_t    shreg;                          // Bits still to send

  // Own free running bit clock
  clk_edge_divider #(.COUNT(COUNT), .WIDTH(WIDTH)) div_bit_clk (
    .hwclk(hwclk), .rst_n(rst_n),
    .clk_out(bit_clk_out), .past_clk_out(past_bit_clk)
  );

  assign fall = !bit_clk_out && past_bit_clk;

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      hold        <= '0;                      // Silence until first sample
      word_select <= 1'b0;
      dac_out     <= 1'b0;
    end else begin
      if (out_valid) begin
        hold <= out_sample >> vol;            // Volume applied on latch
      end
      if (fall) begin
        bit_cnt     <= bit_cnt + 1'b1;
        word_select <= bit_cnt[3];            // Low during data half
        if (bit_cnt[3]) begin
          dac_out <= 1'b0;                    // Idle half of frame
        end else if (bit_cnt == 4'd0) begin
          dac_out <= hold[7];                 // MSB opens the word
        end else begin
          dac_out <= shreg[7];
        end
      end
    end
  end

  // Frame snapshot so a mid-frame latch does not corrupt the word
  always_ff @(posedge hwclk) begin
    if (fall) begin
      if (bit_cnt == 4'd0) begin
        shreg <= {hold[6:0], 1'b0};
      end else begin
        shreg <= {shreg[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== walkie_audio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module walkie_audio_top #(
  parameter int DELAY_SAMPLES = 64,           // Echo distance in samples
  parameter int CREDITS       = 2,            // Memory requests in flight
  parameter int BIT_DIV       = 15            // Bit clock half period count
) (
  input  logic                          hwclk,
  input  logic                          rst_n,
  input  logic                          adc_serial_in,
  input  logic [1:0]                    effect,
  input  logic [2:0]                    vol,
  input  logic [walkie_pkg::DATA_W-1:0] wdati,
  input  logic                          wack,
  output logic                          ws_adc,      // Word select to ADC
  output logic                          i2sclk,      // ADC bit clock
  output logic                          i2sclk_out,  // DAC bit clock
  output logic                          dac_out,
  output logic                          word_select, // Word select to DAC
  output logic [walkie_pkg::ADDR_W-1:0] wadr,
  output logic [walkie_pkg::DATA_W-1:0] wdato,
  output logic [walkie_pkg::SEL_W-1:0]  wsel,
  output logic                          wwe,
  output logic                          wstb,
  output logic                          wcyc
);
  import walkie_pkg::*;

  localparam int BIT_W = $clog2(BIT_DIV + 1);  // Divider counter width

  logic    past_i2sclk;
  sample_t mic_sample;                        // Receiver to echo engine
  logic    mic_valid;
  sample_t fx_sample;                         // Echo engine to transmitter
  logic    fx_valid;

  mem_req_if mem_link ();                     // Echo engine to bus manager

  clk_edge_divider #(.COUNT(BIT_DIV), .WIDTH(BIT_W)) div_i2sclk (
    .hwclk(hwclk), .rst_n(rst_n),
    .clk_out(i2sclk), .past_clk_out(past_i2sclk)
  );

  i2s_receiver adc (
    .hwclk(hwclk), .rst_n(rst_n), .adc_serial_in(adc_serial_in),
    .bit_clk(i2sclk), .past_bit_clk(past_i2sclk),      // Edge detect inputs
    .ws(ws_adc), .sample(mic_sample), .sample_valid(mic_valid)
  );

  echo_engine #(.DELAY_SAMPLES(DELAY_SAMPLES), .CREDITS(CREDITS)) echo (
    .hwclk(hwclk), .rst_n(rst_n), .effect(effect_e'(effect)),
    .sample(mic_sample), .sample_valid(mic_valid),
    .mem(mem_link.requester),
    .out_sample(fx_sample), .out_valid(fx_valid)
  );

  wishbone_manager #(.CREDITS(CREDITS)) wb_mgr (
    .hwclk(hwclk), .rst_n(rst_n), .mem(mem_link.responder),
    .wdati(wdati), .wack(wack),                        // From SRAM bus
    .wadr(wadr), .wdato(wdato), .wsel(wsel),
    .wwe(wwe), .wstb(wstb), .wcyc(wcyc)
  );

  i2s_transmitter #(.COUNT(BIT_DIV), .WIDTH(BIT_W)) dac (
    .hwclk(hwclk), .rst_n(rst_n),
    .out_sample(fx_sample), .out_valid(fx_valid), .vol(vol),
    .bit_clk_out(i2sclk_out), .dac_out(dac_out), .word_select(word_select)
  );

endmodule

`default_nettype wire

// ==== wb_sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_sram_model (
  input  logic        hwclk,
  input  logic        rst_n,
  input  logic [31:0] wadr,                   // Byte address from the manager
  input  logic [31:0] wdato,                  // Write data from the manager
  input  logic [3:0]  wsel,
  input  logic        wwe,
  input  logic        wstb,
  input  logic        wcyc,
  output logic [31:0] wdati,                  // Read data to the manager
  output logic        wack
);

  logic [31:0] mem [256];                     // Word storage
  logic        busy;                          // Cycle seen, delay running
  int          wait_cnt;                      // Cycles left before ack
  integer      seed;
  int          i;

  initial begin
    seed = 24;
    for (i = 0; i < 256; i++) begin
      mem[i] = '0;                            // SRAM starts silent
    end
  end

  always @(posedge hwclk) begin
    if (!rst_n) begin
      wack  <= 1'b0;
      busy  <= 1'b0;
      wdati <= '0;
    end else begin
      wack <= 1'b0;
      if (wcyc && wstb && !wack) begin
        if (!busy) begin
          busy     <= 1'b1;
          wait_cnt <= {$random(seed)} % 4;    // 0 to 3 extra cycles
        end else if (wait_cnt == 0) begin
          wack <= 1'b1;
          busy <= 1'b0;
          if (wwe) begin
            for (int b = 0; b < 4; b++) begin
              if (wsel[b]) begin
                mem[wadr[9:2]][8*b +: 8] <= wdato[8*b +: 8];  // Lane write
              end
            end
          end else begin
            wdati <= mem[wadr[9:2]];
          end
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== walkie_audio_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module walkie_audio_asserts #(
  parameter int CREDITS = 2,
  parameter int CNT_W   = 2
) (
  input logic             hwclk,
  input logic             rst_n,
  input logic             wstb,
  input logic             wcyc,
  input logic             wack,
  input logic [31:0]      wadr,
  input logic [3:0]       wsel,
  input logic             wwe,
  input logic [CNT_W-1:0] fifo_count       // Requests queued or on the bus
);

  stb_needs_cyc: assert property (@(posedge hwclk) disable iff (!rst_n) wstb |-> wcyc)
    else $error("stb high without cyc");

  stb_held: assert property (@(posedge hwclk) disable iff (!rst_n) wstb && !wack |=> wstb)
    else $error("stb dropped before ack");

  bus_stable: assert property (@(posedge hwclk) disable iff (!rst_n)
    wstb && !wack |=> $stable(wadr) && $stable(wsel) && $stable(wwe))
    else $error("bus signals changed while waiting for ack");

  credit_limit: assert property (@(posedge hwclk) disable iff (!rst_n)
    fifo_count <= CNT_W'(CREDITS))
    else $error("more requests in flight than credits");

endmodule

bind wishbone_manager walkie_audio_asserts #(
  .CREDITS(CREDITS), .CNT_W($clog2(CREDITS + 1))
) wb_checks (
  .hwclk(hwclk), .rst_n(rst_n), .wstb(wstb), .wcyc(wcyc), .wack(wack),
  .wadr(wadr), .wsel(wsel), .wwe(wwe), .fifo_count(fifo_count)
);

`default_nettype wire

// ==== walkie_audio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module walkie_audio_tb;

  localparam int DELAY = 4;                   // Short echo keeps the run brief
  localparam int BUF   = DELAY * 2;
  localparam int NROWS = 7;
  localparam int NS    = 4;                   // Samples per row
  localparam int LIMIT = 2000;                // Cycles allowed per wait

  logic        hwclk, rst_n, adc_serial_in, wack;
  logic [1:0]  effect;
  logic [2:0]  vol;
  logic [31:0] wdati, wadr, wdato;
  logic [3:0]  wsel;
  logic        ws_adc, i2sclk, i2sclk_out, dac_out, word_select, wwe, wstb, wcyc;

  string       row_name [NROWS];
  logic [1:0]  row_eff  [NROWS];
  logic [2:0]  row_vol  [NROWS];
  logic [7:0]  row_smp  [NROWS][NS];
  logic [7:0]  hist [$];                      // Echo mode inputs in order
  logic [7:0]  exp_q [$];                     // Expected DAC words
  string       exp_name [$];
  logic [7:0]  dac_q [$];                     // Words seen on the DAC
  logic [7:0]  dac_shift;
  int          dac_bits, bus_ops, errors;
  bit          dac_armed, dac_prev, quiet_check;

  walkie_audio_top #(.DELAY_SAMPLES(DELAY), .CREDITS(2), .BIT_DIV(15)) dut0 (
    .hwclk(hwclk), .rst_n(rst_n), .adc_serial_in(adc_serial_in), .effect(effect),
    .vol(vol), .wdati(wdati), .wack(wack), .ws_adc(ws_adc), .i2sclk(i2sclk),
    .i2sclk_out(i2sclk_out), .dac_out(dac_out), .word_select(word_select),
    .wadr(wadr), .wdato(wdato), .wsel(wsel), .wwe(wwe), .wstb(wstb), .wcyc(wcyc)
  );

  wb_sram_model sram (
    .hwclk(hwclk), .rst_n(rst_n), .wadr(wadr), .wdato(wdato), .wsel(wsel),
    .wwe(wwe), .wstb(wstb), .wcyc(wcyc), .wdati(wdati), .wack(wack)
  );

  initial begin
    hwclk = 1'b0;
    forever #2 hwclk = ~hwclk;                // 4 ns period
  end

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("errors: %0d", errors + 1);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, got);
    end
  endtask

  task automatic wait_ws(input logic level);
    int cnt;
    cnt = 0;
    while (ws_adc !== level) begin
      @(negedge hwclk);
      cnt++;
      if (cnt > LIMIT) abort_run("ADC word select did not change");
    end
  endtask

  task automatic wait_bit_clk(input logic level);
    int cnt;
    cnt = 0;
    while (i2sclk !== level) begin
      @(negedge hwclk);
      cnt++;
      if (cnt > LIMIT) abort_run("ADC bit clock stopped");
    end
  endtask

  // One ADC frame, MSB first, data set while the bit clock is low
  task automatic send_sample(input logic [7:0] s, input bit quiet);
    wait_ws(1'b1);
    wait_ws(1'b0);                            // Frame start
    quiet_check = quiet;
    for (int i = 7; i >= 0; i--) begin
      wait_bit_clk(1'b0);
      adc_serial_in = s[i];
      wait_bit_clk(1'b1);                     // Captured on the next cycle
    end
    wait_bit_clk(1'b0);                       // Past sample_valid before effect changes
  endtask

  // Expected result from the effect rules
  function automatic logic [7:0] model(input logic [1:0] eff, input logic [7:0] s,
                                       input logic [2:0] v);
    logic [7:0] r;
    int         n;
    n = hist.size();
    case (eff)
      2'd0: r = s;
      2'd1: r = (s >> 1) + ((n >= DELAY) ? (hist[n-DELAY] >> 1) : 8'd0);
      2'd2: r = s >> 1;
      default: r = 8'd0;
    endcase
    return r >> v;
  endfunction

  // Bus cycle against the echo sample index
  task automatic check_bus_op();
    int n;
    int idx;
    bit rd;
    n   = bus_ops >> 1;
    rd  = bus_ops[0];
    idx = rd ? (n + BUF - DELAY) % BUF : n % BUF;
    check_val("bus_we", {31'd0, !rd}, {31'd0, wwe});
    check_val("bus_adr", (idx >> 2) * 4, wadr);
    check_val("bus_sel", 32'd1 << (idx % 4), {28'd0, wsel});
    assert ($onehot(wsel)) else begin
      errors++;
      $display("wsel does not have exactly one bit set");
    end
    if (!rd && n < hist.size()) begin
      check_val("bus_data", {24'd0, hist[n]}, {24'd0, wdato[8*(idx%4) +: 8]});
    end
    bus_ops++;
  endtask

  always @(negedge hwclk) begin
    if (rst_n) begin
      if (quiet_check) begin
        assert (!wcyc) else begin
          errors++;
          $display("Wishbone cycle seen in half_level or mute mode");
        end
      end
      if (wstb && wack) check_bus_op();
      if (word_select) begin
        dac_armed = 1'b1;                     // Aligned to a frame
        dac_bits  = 0;
      end else if (dac_armed && i2sclk_out && !dac_prev) begin
        dac_shift = {dac_shift[6:0], dac_out};
        dac_bits++;
        if (dac_bits == 8) begin
          dac_q.push_back(dac_shift);
          dac_bits = 0;
        end
      end
      dac_prev = i2sclk_out;
    end
  end

  function automatic int first_word();
    foreach (dac_q[i]) if (dac_q[i] != 8'd0) return i;
    return -1;
  endfunction

  initial begin
    int start;
    int cnt;
    row_name = '{"bypass_vol0", "bypass_vol2", "echo_fill", "echo_mix",
                 "half_level", "mute", "bypass_vol5"};
    row_eff  = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd3, 2'd0};
    row_vol  = '{3'd0, 3'd2, 3'd0, 3'd0, 3'd0, 3'd0, 3'd5};
    row_smp  = '{'{8'hA5, 8'h3C, 8'hF0, 8'h81}, '{8'hC8, 8'h7F, 8'h40, 8'hFF},
                 '{8'h90, 8'h22, 8'hE4, 8'h5A}, '{8'h6E, 8'hB1, 8'h08, 8'hF3},
                 '{8'h64, 8'hFF, 8'h13, 8'h80}, '{8'h77, 8'h01, 8'hFE, 8'h42},
                 '{8'hD9, 8'h2B, 8'hFF, 8'h60}};
    rst_n = 1'b0;
    adc_serial_in = 1'b0;
    effect = 2'd0;
    vol = 3'd0;
    errors = 0;
    bus_ops = 0;
    dac_bits = 0;
    dac_armed = 1'b0;
    dac_prev = 1'b0;
    quiet_check = 1'b0;
    repeat (16) @(negedge hwclk);
    rst_n = 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      effect = row_eff[r];
      vol    = row_vol[r];
      for (int k = 0; k < NS; k++) begin
        exp_q.push_back(model(row_eff[r], row_smp[r][k], row_vol[r]));
        exp_name.push_back(row_name[r]);
        if (row_eff[r] == 2'd1) hist.push_back(row_smp[r][k]);
        send_sample(row_smp[r][k], row_eff[r][1]);
      end
    end
    quiet_check = 1'b0;
    cnt = 0;
    start = first_word();
    while (start < 0 || dac_q.size() < start + exp_q.size()) begin
      @(negedge hwclk);
      cnt++;
      start = first_word();
      if (cnt > 4 * LIMIT) abort_run("DAC words did not arrive");
    end
    foreach (exp_q[i]) check_val(exp_name[i], exp_q[i], dac_q[start+i]);
    check_val("bus_op_count", 2 * hist.size(), bus_ops);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== walkie_audio_top.f ====
walkie_pkg.sv
mem_req_if.sv
clk_edge_divider.sv
i2s_receiver.sv
echo_engine.sv
wishbone_manager.sv
i2s_transmitter.sv
walkie_audio_top.sv
wb_sram_model.sv
walkie_audio_asserts.sv
walkie_audio_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the walkie audio testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module walkie_audio_tb -f walkie_audio_top.f \
  --Mdir obj_dir -o walkie_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/walkie_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' sim.log; then
  exit 1
fi
exit 0
